// ==== rtl/ej32_pkg.sv ====
// ****************************************
// ej32 shared definitions
// opcodes, stack ops and operand counts
// ****************************************
package ej32_pkg;

    localparam int BYTE_W = 8;                  // fetch granularity

    // java encodings where they exist, eforth vm ops in unused codes
    typedef enum logic [BYTE_W-1:0] {
        nop           = 8'h00,
        bipush        = 8'h10,
        pop           = 8'h57,
        dup           = 8'h59,
        iadd          = 8'h60,
        isub          = 8'h64,
        ifeq          = 8'h99,
        ifne          = 8'h9a,
        iflt          = 8'h9b,
        ifge          = 8'h9c,
        ifgt          = 8'h9d,
        ifle          = 8'h9e,
        goto          = 8'ha7,
        jreturn       = 8'hb1,              // plain java return
        invokevirtual = 8'hb6,
        donext        = 8'hd0,
        pushr         = 8'hd1,
        popr          = 8'hd2,
        dupr          = 8'hd3,
        iout          = 8'hd4               // tos to output stream
    } opcode_t;

    typedef enum logic [1:0] {
        s_nop,
        s_push,
        s_pop,
        s_move                              // overwrite top in place
    } stack_op_t;

    // operand bytes following the opcode
    function automatic logic [1:0] op_bytes(input opcode_t op);
        case (op)
            bipush:        return 2'd1;
            ifeq, ifne,
            iflt, ifge,
            ifgt, ifle:    return 2'd2;     // 16-bit absolute target
            goto:          return 2'd2;
            invokevirtual: return 2'd2;
            donext:        return 2'd2;
            default:       return 2'd0;
        endcase
    endfunction

endpackage

// ==== rtl/ej32_bus_if.sv ====
// ****************************************
// ej32 internal control bus
// decoder to stack and branch units
// ****************************************
`timescale 1ns/1ps

interface ej32_bus_if #(
    parameter int DSZ = 32
) (
    input logic ctl,
    input logic reset
);
    ej32_pkg::opcode_t              code;   // current opcode
    logic                           phase;  // operand index
    logic                           step;   // phase done, units update
    logic [ej32_pkg::BYTE_W-1:0]    data;   // byte just fetched
    logic [DSZ-1:0]                 t;      // tos from stack unit
    logic [DSZ-1:0]                 br_t;   // rs value toward tos
    logic                           br_t_we;

    modport decode (
        input  ctl, reset,
        output code, phase, step, data
    );

    modport stack (
        input  ctl, reset, code, phase, step, data, br_t, br_t_we,
        output t
    );

    modport branch (
        input  ctl, reset, code, phase, step, data, t,
        output br_t, br_t_we
    );

endinterface

// ==== rtl/ej32_decode.sv ====
// ****************************************
// ej32 decoder
// byte fetch, operand phases, step strobe
// ****************************************
`timescale 1ns/1ps

module ej32_decode #(
    parameter int ASZ = 16
) (
    ej32_bus_if.decode                      bus,
    input  logic                            fetch_ready,
    input  logic [ej32_pkg::BYTE_W-1:0]     fetch_data,
    input  logic [ASZ-1:0]                  br_pc,
    input  logic                            br_jump,
    input  logic                            result_ready,
    output logic [ASZ-1:0]                  fetch_addr,
    output logic                            fetch_valid,
    output logic                            result_valid
);
    typedef enum logic [1:0] {
        op_fetch,
        operand,
        execute
    } state_t;

    state_t             state;
    ej32_pkg::opcode_t  code_r;             // latched opcode
    ej32_pkg::opcode_t  fetch_op;           // incoming byte as opcode
    logic               phase_r;
    logic [ASZ-1:0]     pc;
    logic [ASZ-1:0]     pc_inc;
    logic               last;               // final operand byte
    logic               is_out;

    assign fetch_op   = ej32_pkg::opcode_t'(fetch_data);
    assign pc_inc     = pc + 1'b1;
    assign last       = {1'b0, phase_r} == (ej32_pkg::op_bytes(code_r) - 2'd1);
    assign is_out     = code_r == ej32_pkg::iout;

    assign fetch_addr   = pc;               // held until accepted
    assign fetch_valid  = !bus.reset && (state != execute);             // quiet in reset
    assign result_valid = !bus.reset && (state == execute) && is_out;

    assign bus.code  = code_r;
    assign bus.phase = phase_r;
    assign bus.data  = fetch_data;          // valid in operand steps

    always_comb begin
        case (state)
            operand: bus.step = fetch_ready;                        // one per byte
            execute: bus.step = is_out ? result_ready : 1'b1;       // stall on output
            default: bus.step = 1'b0;
        endcase
    end

    always_ff @(posedge bus.ctl) begin
        if (bus.reset) begin
            state   <= op_fetch;
            code_r  <= ej32_pkg::nop;
            phase_r <= 1'b0;
            pc      <= '0;                  // cold start at 0
        end else begin
            case (state)
                op_fetch: begin
                    if (fetch_ready) begin
                        code_r  <= fetch_op;
                        phase_r <= 1'b0;
                        pc      <= pc_inc;
                        if (ej32_pkg::op_bytes(fetch_op) == 2'd0) begin
                            state <= execute;
                        end else begin
                            state <= operand;
                        end
                    end
                end
                operand: begin
                    if (bus.step) begin
                        pc <= br_jump ? br_pc : pc_inc;     // branch wins
                        if (last) begin
                            state <= op_fetch;
                        end else begin
                            phase_r <= 1'b1;
                        end
                    end
                end
                execute: begin
                    if (bus.step) begin
                        state <= op_fetch;
                        if (br_jump) begin
                            pc <= br_pc;                    // jreturn
                        end
                    end
                end
                default: state <= op_fetch;
            endcase
        end
    end

endmodule

// ==== rtl/ej32_stack.sv ====
// ****************************************
// ej32 data stack unit
// tos register, arithmetic, output source
// ****************************************
`timescale 1ns/1ps

module ej32_stack #(
    parameter int DSZ      = 32,
    parameter int DS_DEPTH = 16
) (
    ej32_bus_if.stack       bus,
    output logic [DSZ-1:0]  result_data
);
    localparam int SPW = $clog2(DS_DEPTH);

    logic [DSZ-1:0]         ds [DS_DEPTH];  // below tos
    logic [SPW-1:0]         sp;             // points at nos
    logic [SPW-1:0]         sp1;
    logic [DSZ-1:0]         t;              // tos
    logic [DSZ-1:0]         s;              // nos
    logic [DSZ-1:0]         t_n;
    ej32_pkg::stack_op_t    ds_op;

    assign s   = ds[sp];
    assign sp1 = sp + 1'b1;

    assign bus.t       = t;
    assign result_data = t;                 // iout source

    always_comb begin
        t_n   = t;
        ds_op = ej32_pkg::s_nop;
        if (bus.br_t_we) begin
            t_n   = bus.br_t;               // popr, dupr
            ds_op = ej32_pkg::s_push;
        end else begin
            case (bus.code)
                ej32_pkg::bipush: begin
                    t_n   = {{(DSZ-8){bus.data[7]}}, bus.data}; // sign extend
                    ds_op = ej32_pkg::s_push;
                end
                ej32_pkg::dup: begin
                    ds_op = ej32_pkg::s_push;
                end
                ej32_pkg::iadd: begin
                    t_n   = s + t;
                    ds_op = ej32_pkg::s_pop;
                end
                ej32_pkg::isub: begin
                    t_n   = s - t;
                    ds_op = ej32_pkg::s_pop;
                end
                ej32_pkg::pop,
                ej32_pkg::iout,
                ej32_pkg::pushr: begin
                    t_n   = s;
                    ds_op = ej32_pkg::s_pop;
                end
                ej32_pkg::ifeq, ej32_pkg::ifne,
                ej32_pkg::iflt, ej32_pkg::ifge,
                ej32_pkg::ifgt, ej32_pkg::ifle: begin
                    if (bus.phase) begin    // condition consumed on 2nd byte
                        t_n   = s;
                        ds_op = ej32_pkg::s_pop;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge bus.ctl) begin
        if (bus.reset) begin
            t  <= '0;
            sp <= '0;
        end else if (bus.step) begin
            t <= t_n;
            case (ds_op)
                ej32_pkg::s_push: sp <= sp1;
                ej32_pkg::s_pop:  sp <= sp - 1'b1;
                default: ;
            endcase
        end
    end

    // old tos spills below
    always_ff @(posedge bus.ctl) begin
        if (bus.step && ds_op == ej32_pkg::s_push) begin
            ds[sp1] <= t;
        end
    end

endmodule

// ==== rtl/ej32_branch.sv ====
// ****************************************
// ej32 branching unit
// return stack, conditions, calls, donext
// ****************************************
`timescale 1ns/1ps

module ej32_branch #(
    parameter int DSZ      = 32,
    parameter int ASZ      = 16,
    parameter int RS_DEPTH = 16
) (
    ej32_bus_if.branch      bus,
    input  logic [ASZ-1:0]  pc,
    output logic [ASZ-1:0]  br_pc,
    output logic            br_jump
);
    localparam int RPW = $clog2(RS_DEPTH);

    logic [DSZ-1:0]         rs [RS_DEPTH];  // return stack
    logic [RPW-1:0]         rp;             // points at top
    logic [RPW-1:0]         rp1;
    logic [DSZ-1:0]         r;              // top of rs
    logic [DSZ-1:0]         r_n;
    ej32_pkg::stack_op_t    rs_op;
    logic [ASZ-9:0]         a;              // high target byte
    logic [ASZ-1:0]         a_d;            // merged target
    logic [ASZ-1:0]         tgt;
    logic                   jmp;
    logic                   cond;
    logic                   t_z;
    logic                   t_neg;

    assign r     = rs[rp];
    assign rp1   = rp + 1'b1;
    assign a_d   = {a, bus.data};           // phase 1 byte is low
    assign t_z   = bus.t == '0;             // zero flag
    assign t_neg = bus.t[DSZ-1];            // sign flag

    assign bus.br_t = r;                    // popr, dupr source
    assign br_pc    = tgt;
    assign br_jump  = bus.step && jmp;

    always_comb begin
        case (bus.code)
            ej32_pkg::ifeq: cond = t_z;
            ej32_pkg::ifne: cond = !t_z;
            ej32_pkg::iflt: cond = t_neg;
            ej32_pkg::ifge: cond = !t_neg;
            ej32_pkg::ifgt: cond = !t_z && !t_neg;
            ej32_pkg::ifle: cond = t_z || t_neg;
            default:        cond = 1'b1;    // goto, calls
        endcase
    end

    always_comb begin
        tgt         = a_d;
        jmp         = 1'b0;
        r_n         = r;
        rs_op       = ej32_pkg::s_nop;
        bus.br_t_we = 1'b0;
        case (bus.code)
            ej32_pkg::ifeq, ej32_pkg::ifne,
            ej32_pkg::iflt, ej32_pkg::ifge,
            ej32_pkg::ifgt, ej32_pkg::ifle,
            ej32_pkg::goto: begin
                jmp = bus.phase && cond;    // else fall through
            end
            ej32_pkg::invokevirtual: begin
                if (bus.phase) begin
                    r_n   = {{(DSZ-ASZ){1'b0}}, pc} + 1'b1; // after last operand
                    rs_op = ej32_pkg::s_push;
                    jmp   = 1'b1;
                end
            end
            ej32_pkg::jreturn: begin
                tgt   = r[ASZ-1:0];
                jmp   = 1'b1;
                rs_op = ej32_pkg::s_pop;
            end
            ej32_pkg::donext: begin
                if (bus.phase) begin
                    if (r == '0) begin
                        rs_op = ej32_pkg::s_pop;    // loop done
                    end else begin
                        r_n   = r - 1'b1;
                        rs_op = ej32_pkg::s_move;
                        jmp   = 1'b1;
                    end
                end
            end
            ej32_pkg::pushr: begin
                r_n   = bus.t;
                rs_op = ej32_pkg::s_push;
            end
            ej32_pkg::popr: begin
                bus.br_t_we = 1'b1;
                rs_op       = ej32_pkg::s_pop;
            end
            ej32_pkg::dupr: begin
                bus.br_t_we = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge bus.ctl) begin
        if (bus.reset) begin
            rp <= '0;
        end else if (bus.step) begin
            case (rs_op)
                ej32_pkg::s_push: rp <= rp1;
                ej32_pkg::s_pop:  rp <= rp - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge bus.ctl) begin
        if (bus.step) begin
            if (!bus.phase) begin
                a <= (ASZ-8)'(bus.data);    // high byte first
            end
            case (rs_op)
                ej32_pkg::s_push: rs[rp1] <= r_n;
                ej32_pkg::s_move: rs[rp]  <= r_n;   // donext count
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/ej32_core.sv ====
// ****************************************
// ej32 core top level
// decoder, data stack and branch unit
// ****************************************
`timescale 1ns/1ps

module ej32_core #(
    parameter int DSZ      = 32,
    parameter int ASZ      = 16,
    parameter int RS_DEPTH = 16,
    parameter int DS_DEPTH = 16
) (
    input  logic                        ctl,
    input  logic                        reset,
    input  logic                        fetch_ready,
    input  logic [ej32_pkg::BYTE_W-1:0] fetch_data,
    input  logic                        result_ready,
    output logic [ASZ-1:0]              fetch_addr,
    output logic                        fetch_valid,
    output logic                        result_valid,
    output logic [DSZ-1:0]              result_data
);
    logic [ASZ-1:0] br_pc;                  // branch target
    logic           br_jump;

    ej32_bus_if #(.DSZ(DSZ)) bus (
        .ctl   (ctl),
        .reset (reset)
    );

    ej32_decode #(.ASZ(ASZ)) decode_i (
        .bus          (bus.decode),
        .fetch_ready  (fetch_ready),
        .fetch_data   (fetch_data),
        .br_pc        (br_pc),
        .br_jump      (br_jump),
        .result_ready (result_ready),
        .fetch_addr   (fetch_addr),
        .fetch_valid  (fetch_valid),
        .result_valid (result_valid)
    );

    ej32_stack #(.DSZ(DSZ), .DS_DEPTH(DS_DEPTH)) stack_i (
        .bus         (bus.stack),
        .result_data (result_data)
    );

    ej32_branch #(.DSZ(DSZ), .ASZ(ASZ), .RS_DEPTH(RS_DEPTH)) branch_i (
        .bus     (bus.branch),
        .pc      (fetch_addr),              // decoder pc
        .br_pc   (br_pc),
        .br_jump (br_jump)
    );

endmodule

// ==== tests/ej32_core_asserts.sv ====
// ****************************************
// ej32 core handshake and reset checks
// ****************************************
`timescale 1ns/1ps

module ej32_core_asserts #(
    parameter int DSZ = 32,
    parameter int ASZ = 16
) (
    input logic             ctl,
    input logic             reset,
    input logic             fetch_valid,
    input logic             fetch_ready,
    input logic [ASZ-1:0]   fetch_addr,
    input logic             result_valid,
    input logic             result_ready,
    input logic [DSZ-1:0]   result_data,
    input logic             br_jump
);
    int unsigned fail_count = 0;            // failed assertions so far

    // request held with a fixed address until accepted
    property fetch_held;
        @(posedge ctl) disable iff (reset)
        fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch_addr);
    endproperty

    // output word frozen under back-pressure
    property result_held;
        @(posedge ctl) disable iff (reset)
        result_valid && !result_ready |=> result_valid && $stable(result_data);
    endproperty

    // both handshakes quiet in reset, clean start behind it
    property reset_state;
        @(posedge ctl)
        reset |-> (!fetch_valid && !result_valid) ##1 (!br_jump && fetch_addr == '0);
    endproperty

    fetch_held_a: assert property (fetch_held) else begin
        $error("fetch address or request changed before the byte was accepted");
        fail_count++;
    end

    result_held_a: assert property (result_held) else begin
        $error("result word changed or dropped before it was taken");
        fail_count++;
    end

    reset_state_a: assert property (reset_state) else begin
        $error("core showed a request or output in reset, or a jump or nonzero pc after it");
        fail_count++;
    end

endmodule

bind ej32_core ej32_core_asserts #(.DSZ(DSZ), .ASZ(ASZ)) asserts_i (
    .ctl          (ctl),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .fetch_ready  (fetch_ready),
    .fetch_addr   (fetch_addr),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result_data  (result_data),
    .br_jump      (br_jump)
);

// ==== tests/ej32_core_tb.sv ====
// ****************************************
// ej32 core testbench
// program memory, result stream checker
// ****************************************
`timescale 1ns/1ps

module ej32_core_tb;
    localparam int DSZ       = 32;
    localparam int ASZ       = 16;
    localparam int MEM_SIZE  = 1024;
    localparam int RUN_LIMIT = 40000;       // cycles per program run

    logic               ctl;
    logic               reset;
    logic               fetch_ready;
    logic [7:0]         fetch_data;
    logic               result_ready;
    logic [ASZ-1:0]     fetch_addr;
    logic               fetch_valid;
    logic               result_valid;
    logic [DSZ-1:0]     result_data;

    logic [7:0]         mem [MEM_SIZE];     // program image
    logic [DSZ-1:0]     exp_all [$];        // full expected stream
    logic [DSZ-1:0]     exp_q [$];          // still to come in this run
    int                 asm_pc;
    logic               full_speed;
    integer             seed = 32'h1abe;

    ej32_pkg::opcode_t  cond_ops [6] = '{ej32_pkg::ifeq, ej32_pkg::ifne, ej32_pkg::iflt,
                                         ej32_pkg::ifge, ej32_pkg::ifgt, ej32_pkg::ifle};
    int                 cond_vals [3] = '{0, -3, 5};

    ej32_core #(.DSZ(DSZ), .ASZ(ASZ)) dut_i (
        .ctl          (ctl),
        .reset        (reset),
        .fetch_ready  (fetch_ready),
        .fetch_data   (fetch_data),
        .result_ready (result_ready),
        .fetch_addr   (fetch_addr),
        .fetch_valid  (fetch_valid),
        .result_valid (result_valid),
        .result_data  (result_data)
    );

    initial begin
        ctl = 1'b0;
        forever #50 ctl = ~ctl;
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at first error");
    endtask

    function automatic logic ready_draw();
        logic [31:0] r;
        r = $random(seed);
        return r[1:0] != 2'b00;             // ready about 3 cycles in 4
    endfunction

    // java branch semantics on a signed tos
    function automatic bit cond_holds(input ej32_pkg::opcode_t op, input int v);
        case (op)
            ej32_pkg::ifeq: return v == 0;
            ej32_pkg::ifne: return v != 0;
            ej32_pkg::iflt: return v < 0;
            ej32_pkg::ifge: return v >= 0;
            ej32_pkg::ifgt: return v > 0;
            ej32_pkg::ifle: return v <= 0;
            default:        return 1'b1;
        endcase
    endfunction

    task automatic write_byte(input logic [7:0] b);
        mem[asm_pc] = b;
        asm_pc++;
    endtask

    task automatic place_op(input ej32_pkg::opcode_t op);
        write_byte(op);
    endtask

    task automatic push_literal(input int v);
        write_byte(ej32_pkg::bipush);
        write_byte(8'(v));                  // low byte, sign extended by core
    endtask

    // slot marks the high target byte for later patching
    task automatic jump_to(input ej32_pkg::opcode_t op, input int target, output int slot);
        if (ej32_pkg::op_bytes(op) != 2'd2) begin
            fail_now("program builder used a jump with an opcode that takes no address");
        end
        write_byte(op);
        slot = asm_pc;
        write_byte(8'(target >> 8));        // high byte first
        write_byte(8'(target));
    endtask

    task automatic patch_target(input int slot, input int target);
        mem[slot]     = 8'(target >> 8);
        mem[slot + 1] = 8'(target);
    endtask

    task automatic expect_value(input int v);
        exp_all.push_back(v);
    endtask

    task automatic assemble_program();
        int slot;
        int slot_end;
        int f1;
        int f2;
        int top;
        int idx;
        for (int a = 0; a < MEM_SIZE; a++) begin
            mem[a] = 8'(a ^ (a >> 5)) ^ 8'ha5;  // filler, never reached
        end
        asm_pc = 0;
        // arithmetic stream
        push_literal(-5);
        push_literal(7);
        place_op(ej32_pkg::iadd);
        place_op(ej32_pkg::dup);
        place_op(ej32_pkg::iout);
        expect_value(-5 + 7);
        push_literal(100);
        place_op(ej32_pkg::isub);           // nos minus tos
        place_op(ej32_pkg::iout);
        expect_value((-5 + 7) - 100);
        push_literal(-128);
        push_literal(127);
        place_op(ej32_pkg::isub);
        place_op(ej32_pkg::iout);
        expect_value(-128 - 127);
        push_literal(3);
        place_op(ej32_pkg::nop);
        push_literal(9);
        place_op(ej32_pkg::pop);
        place_op(ej32_pkg::iout);
        expect_value(3);
        // six conditions, each on zero, negative and positive tos
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 3; j++) begin
                idx = i * 3 + j;
                push_literal(8'h60 + idx);  // sentinel under the condition
                push_literal(cond_vals[j]);
                jump_to(cond_ops[i], 0, slot);
                push_literal(8'h20 + idx);  // fall-through marker
                place_op(ej32_pkg::iout);
                jump_to(ej32_pkg::goto, 0, slot_end);
                patch_target(slot, asm_pc);
                push_literal(8'h40 + idx);  // taken marker
                place_op(ej32_pkg::iout);
                patch_target(slot_end, asm_pc);
                place_op(ej32_pkg::iout);   // sentinel shows the pop
                expect_value(cond_holds(cond_ops[i], cond_vals[j]) ? 8'h40 + idx : 8'h20 + idx);
                expect_value(8'h60 + idx);
            end
        end
        // nested calls, subroutines placed inline behind a goto
        jump_to(ej32_pkg::goto, 0, slot_end);
        f2 = asm_pc;
        push_literal(3);
        place_op(ej32_pkg::iout);
        place_op(ej32_pkg::jreturn);
        f1 = asm_pc;
        push_literal(2);
        place_op(ej32_pkg::iout);
        jump_to(ej32_pkg::invokevirtual, f2, slot);
        push_literal(4);
        place_op(ej32_pkg::iout);
        place_op(ej32_pkg::jreturn);
        patch_target(slot_end, asm_pc);
        push_literal(1);
        place_op(ej32_pkg::iout);
        jump_to(ej32_pkg::invokevirtual, f1, slot);
        push_literal(5);
        place_op(ej32_pkg::iout);
        for (int k = 1; k <= 5; k++) begin
            expect_value(k);
        end
        jump_to(ej32_pkg::goto, 0, slot_end);
        push_literal(8'h7e);                // dead code
        place_op(ej32_pkg::iout);
        patch_target(slot_end, asm_pc);
        // rs round trip
        push_literal(9);
        place_op(ej32_pkg::pushr);
        place_op(ej32_pkg::popr);
        place_op(ej32_pkg::iout);
        expect_value(9);
        // counted loop, n down to 0
        push_literal(8'h33);
        push_literal(4);
        place_op(ej32_pkg::pushr);
        top = asm_pc;
        place_op(ej32_pkg::dupr);
        place_op(ej32_pkg::iout);
        jump_to(ej32_pkg::donext, top, slot);
        place_op(ej32_pkg::iout);           // data stack untouched by loop
        for (int k = 4; k >= 0; k--) begin
            expect_value(k);
        end
        expect_value(8'h33);
        top = asm_pc;
        jump_to(ej32_pkg::goto, top, slot); // park
    endtask

    // memory side, data only offered once the address is known stable
    always @(posedge ctl) begin
        if (reset) begin
            fetch_ready  <= 1'b0;
            result_ready <= 1'b0;
        end else begin
            if (fetch_valid && !fetch_ready) begin
                fetch_data  <= mem[fetch_addr[9:0]];
                fetch_ready <= full_speed ? 1'b1 : ready_draw();
            end else begin
                fetch_ready <= 1'b0;        // byte taken or no request
            end
            result_ready <= full_speed ? 1'b1 : ready_draw();
        end
    end

    always @(posedge ctl) begin
        if (!reset && result_valid && result_ready) begin
            if (exp_q.size() == 0) begin
                fail_now($sformatf("result %h appeared when no result was due", result_data));
            end else begin
                assert (result_data == exp_q[0]) void'(exp_q.pop_front());
                else fail_now($sformatf("CHECK FAILED result_data got %h expected %h",
                                        result_data, exp_q[0]));
            end
        end
    end

    always @(posedge ctl) begin
        if (dut_i.asserts_i.fail_count != 0) begin
            fail_now("a bound handshake or reset assertion failed");
        end
    end

    task automatic run_program(input logic fast);
        int cycles;
        reset      <= 1'b1;
        full_speed <= fast;
        @(posedge ctl);
        exp_q = exp_all;
        repeat (9) @(posedge ctl);
        reset <= 1'b0;
        cycles = 0;
        while (!(fetch_valid && fetch_ready) && cycles < 100) begin
            @(posedge ctl);
            cycles++;
        end
        if (cycles >= 100) begin
            fail_now("no opcode fetch was accepted after reset");
        end
        assert (fetch_addr == '0)
        else fail_now($sformatf("CHECK FAILED fetch_addr got %h expected %h", fetch_addr, 16'h0));
        cycles = 0;
        while (exp_q.size() != 0 && cycles < RUN_LIMIT) begin
            @(posedge ctl);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            fail_now($sformatf("timed out with %0d results still missing", exp_q.size()));
        end
        repeat (60) @(posedge ctl);         // no stray output while parked
    endtask

    initial begin
        reset        = 1'b1;
        fetch_ready  = 1'b0;
        fetch_data   = 8'h00;
        result_ready = 1'b0;
        full_speed   = 1'b1;
        assemble_program();
        run_program(1'b1);
        run_program(1'b0);                  // random handshakes, same stream
        if (exp_q.size() != 0 || dut_i.asserts_i.fail_count != 0) begin
            fail_now("run ended with pending results or failed assertions");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// ==== ej32_core.f ====
rtl/ej32_pkg.sv
rtl/ej32_bus_if.sv
rtl/ej32_decode.sv
rtl/ej32_stack.sv
rtl/ej32_branch.sv
rtl/ej32_core.sv
tests/ej32_core_asserts.sv
tests/ej32_core_tb.sv
